//--- hw/mem_adapter_pkg.sv
// shared widths, enums, request and return structs for the memory adapter; import where needed
package mem_adapter_pkg;

  localparam int unsigned WORD_W     = 64;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned PADDR_W    = 32;
  localparam int unsigned TID_W      = 2;
  localparam int unsigned BLEN_W     = $clog2(LINE_WORDS);
  localparam int unsigned REQ_DEPTH  = 2;
  localparam int unsigned META_DEPTH = 4;

  // byte offset within a word and within a line
  localparam int unsigned BYTE_OFFS_W = $clog2(WORD_W / 8);
  localparam int unsigned LINE_OFFS_W = BYTE_OFFS_W + $clog2(LINE_WORDS);

  localparam logic BUS_ID_ICACHE = 1'b0;
  localparam logic BUS_ID_DCACHE = 1'b1;

  typedef enum logic {
    DC_LOAD  = 1'b0,
    DC_STORE = 1'b1
  } dcache_op_e;

  typedef enum logic {
    DC_LOAD_ACK  = 1'b0,
    DC_STORE_ACK = 1'b1
  } dcache_ack_e;

  typedef struct packed {
    logic [PADDR_W-1:0] paddr;
    logic               nc;
    logic [TID_W-1:0]   tid;
  } icache_req_t;

  typedef struct packed {
    logic [TID_W-1:0]                   tid;
    logic [LINE_WORDS-1:0][WORD_W-1:0]  data;
  } icache_rtrn_t;

  typedef struct packed {
    dcache_op_e         op;
    logic [PADDR_W-1:0] paddr;
    logic [1:0]         size;
    logic [WORD_W-1:0]  data;
    logic [TID_W-1:0]   tid;
  } dcache_req_t;

  typedef struct packed {
    dcache_ack_e        rtype;
    logic [TID_W-1:0]   tid;
    logic [WORD_W-1:0]  data;
  } dcache_rtrn_t;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    logic [BLEN_W-1:0]  blen;
    logic [1:0]         size;
    logic               id;
  } bus_rd_req_t;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    logic [WORD_W-1:0]  data;
    logic [7:0]         be;
    logic [1:0]         size;
    logic               id;
  } bus_wr_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              id;
    logic              last;
  } bus_rd_rsp_t;

  // size is log2 of the byte count, lanes are aligned to the size
  function automatic logic [7:0] be_from_size(input logic [2:0] offs, input logic [1:0] size);
    logic [7:0] be;
    unique case (size)
      2'b00:   be = 8'h01 << offs;
      2'b01:   be = 8'h03 << {offs[2:1], 1'b0};
      2'b10:   be = 8'h0f << {offs[2], 2'b00};
      default: be = 8'hff;
    endcase
    return be;
  endfunction

endpackage

//--- hw/sync_fifo.sv
// synchronous circular-buffer FIFO of any type and depth, head visible on data_o
module sync_fifo #(
  parameter type         data_t = logic,
  parameter int unsigned DEPTH  = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output logic  full_o,
  output logic  empty_o,
  output data_t data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  data_t            mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // occupancy only moves when exactly one side is active
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o));

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_i && empty_o));

endmodule

//--- hw/ifill_port.sv
// instruction refill side: queues refill requests, tracks tids and assembles returned lines
module ifill_port (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          icache_req_i,
  input  mem_adapter_pkg::icache_req_t  icache_i,
  output logic                          icache_ack_o,
  output logic                          req_vld_o,
  output mem_adapter_pkg::bus_rd_req_t  req_o,
  input  logic                          pop_i,
  input  logic                          rd_rsp_vld_i,
  input  mem_adapter_pkg::bus_rd_rsp_t  rd_rsp_i,
  output logic                          icache_rtrn_vld_o,
  output mem_adapter_pkg::icache_rtrn_t icache_rtrn_o
);
  import mem_adapter_pkg::*;

  icache_req_t                       head;
  logic                              req_full, req_empty;
  logic [TID_W-1:0]                  tid_head, tid_q;
  logic                              tid_full;
  logic                              beat_en, rtrn_vld_d, rtrn_vld_q;
  logic                              first_d, first_q;
  logic [LINE_WORDS-1:0][WORD_W-1:0] line_d, line_q;

  assign icache_ack_o = icache_req_i & ~req_full;

  sync_fifo #(
    .data_t (icache_req_t),
    .DEPTH  (REQ_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (icache_ack_o),
    .data_i  (icache_i),
    .pop_i   (pop_i),
    .full_o  (req_full),
    .empty_o (req_empty),
    .data_o  (head)
  );

  // one tid per granted refill, released on the last beat
  sync_fifo #(
    .data_t (logic [TID_W-1:0]),
    .DEPTH  (META_DEPTH)
  ) i_tid_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (pop_i),
    .data_i  (head.tid),
    .pop_i   (rtrn_vld_d),
    .full_o  (tid_full),
    .empty_o (),
    .data_o  (tid_head)
  );

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  assign req_vld_o = ~req_empty & ~tid_full;

  always_comb begin
    req_o      = '0;
    req_o.id   = BUS_ID_ICACHE;
    req_o.size = 2'b11;
    if (head.nc) begin
      req_o.addr = {head.paddr[PADDR_W-1:BYTE_OFFS_W], {BYTE_OFFS_W{1'b0}}};
      req_o.blen = '0;
    end else begin
      req_o.addr = {head.paddr[PADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
      req_o.blen = BLEN_W'(LINE_WORDS - 1);
    end
  end

  ////////////////////////////////////////////////////////////
  // return side
  ////////////////////////////////////////////////////////////

  assign beat_en    = rd_rsp_vld_i & (rd_rsp_i.id == BUS_ID_ICACHE);
  assign rtrn_vld_d = beat_en & rd_rsp_i.last;

  always_comb begin
    line_d  = line_q;
    first_d = first_q;
    if (beat_en) begin
      first_d = rd_rsp_i.last;
      line_d  = {rd_rsp_i.data, line_q[LINE_WORDS-1:1]};
      // a single-word transfer has to end up at offset 0
      if (first_q) begin
        line_d[0] = rd_rsp_i.data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q    <= 1'b1;
      rtrn_vld_q <= 1'b0;
    end else begin
      first_q    <= first_d;
      rtrn_vld_q <= rtrn_vld_d;
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
    if (rtrn_vld_d) begin
      tid_q <= tid_head;
    end
  end

  assign icache_rtrn_vld_o  = rtrn_vld_q;
  assign icache_rtrn_o.tid  = tid_q;
  assign icache_rtrn_o.data = line_q;

endmodule

//--- hw/dcache_port.sv
// data side: queues loads and stores, tracks read and write tids, builds load and store returns
module dcache_port (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          dcache_req_i,
  input  mem_adapter_pkg::dcache_req_t  dcache_i,
  output logic                          dcache_ack_o,
  output logic                          rd_vld_o,
  output mem_adapter_pkg::bus_rd_req_t  rd_o,
  output logic                          wr_vld_o,
  output mem_adapter_pkg::bus_wr_req_t  wr_o,
  input  logic                          pop_i,
  input  logic                          rd_rsp_vld_i,
  input  mem_adapter_pkg::bus_rd_rsp_t  rd_rsp_i,
  input  logic                          wr_rsp_vld_i,
  output logic                          wr_rsp_rdy_o,
  output logic                          dcache_rtrn_vld_o,
  output mem_adapter_pkg::dcache_rtrn_t dcache_rtrn_o
);
  import mem_adapter_pkg::*;

  dcache_req_t       head;
  logic              req_full, req_empty, is_load;
  logic [TID_W-1:0]  rd_tid, wr_tid, tid_q;
  logic              rd_tid_full, wr_tid_full, wr_tid_empty;
  logic              rd_beat, load_done, store_done, rtrn_vld_q;
  dcache_ack_e       rtype_q;
  logic [WORD_W-1:0] data_q;

  assign dcache_ack_o = dcache_req_i & ~req_full;
  assign is_load      = (head.op == DC_LOAD);

  sync_fifo #(
    .data_t (dcache_req_t),
    .DEPTH  (REQ_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_ack_o),
    .data_i  (dcache_i),
    .pop_i   (pop_i),
    .full_o  (req_full),
    .empty_o (req_empty),
    .data_o  (head)
  );

  sync_fifo #(
    .data_t (logic [TID_W-1:0]),
    .DEPTH  (META_DEPTH)
  ) i_rd_tid_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (pop_i & is_load),
    .data_i  (head.tid),
    .pop_i   (load_done),
    .full_o  (rd_tid_full),
    .empty_o (),
    .data_o  (rd_tid)
  );

  sync_fifo #(
    .data_t (logic [TID_W-1:0]),
    .DEPTH  (META_DEPTH)
  ) i_wr_tid_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (pop_i & ~is_load),
    .data_i  (head.tid),
    .pop_i   (store_done),
    .full_o  (wr_tid_full),
    .empty_o (wr_tid_empty),
    .data_o  (wr_tid)
  );

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  assign rd_vld_o = ~req_empty & is_load & ~rd_tid_full;
  assign wr_vld_o = ~req_empty & ~is_load & ~wr_tid_full;

  // loads are always a single beat
  assign rd_o.addr = head.paddr;
  assign rd_o.blen = '0;
  assign rd_o.size = head.size;
  assign rd_o.id   = BUS_ID_DCACHE;

  assign wr_o.addr = head.paddr;
  assign wr_o.data = head.data;
  assign wr_o.be   = be_from_size(head.paddr[2:0], head.size);
  assign wr_o.size = head.size;
  assign wr_o.id   = BUS_ID_DCACHE;

  ////////////////////////////////////////////////////////////
  // returns, read beats win over write responses
  ////////////////////////////////////////////////////////////

  assign rd_beat      = rd_rsp_vld_i & (rd_rsp_i.id == BUS_ID_DCACHE);
  assign load_done    = rd_beat & rd_rsp_i.last;
  assign wr_rsp_rdy_o = ~rd_beat;
  assign store_done   = wr_rsp_vld_i & wr_rsp_rdy_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtrn_vld_q <= 1'b0;
    end else begin
      rtrn_vld_q <= load_done | store_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_done) begin
      rtype_q <= DC_LOAD_ACK;
      tid_q   <= rd_tid;
      data_q  <= rd_rsp_i.data;
    end else if (store_done) begin
      rtype_q <= DC_STORE_ACK;
      tid_q   <= wr_tid;
    end
  end

  assign dcache_rtrn_vld_o   = rtrn_vld_q;
  assign dcache_rtrn_o.rtype = rtype_q;
  assign dcache_rtrn_o.tid   = tid_q;
  assign dcache_rtrn_o.data  = data_q;

  // a write response needs an outstanding granted store
  a_wr_rsp_has_tid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_done |-> !wr_tid_empty);

endmodule

//--- hw/bus_arbiter.sv
// round-robin arbiter merging refill and data requests onto the bus read and write channels
module bus_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ic_vld_i,
  input  mem_adapter_pkg::bus_rd_req_t ic_rd_i,
  input  logic                         dc_rd_vld_i,
  input  mem_adapter_pkg::bus_rd_req_t dc_rd_i,
  input  logic                         dc_wr_vld_i,
  input  mem_adapter_pkg::bus_wr_req_t dc_wr_i,
  output logic                         ic_pop_o,
  output logic                         dc_pop_o,
  output logic                         bus_rd_req_o,
  output mem_adapter_pkg::bus_rd_req_t bus_rd_o,
  input  logic                         bus_rd_gnt_i,
  output logic                         bus_wr_req_o,
  output mem_adapter_pkg::bus_wr_req_t bus_wr_o,
  input  logic                         bus_wr_gnt_i
);
  import mem_adapter_pkg::*;

  logic dc_vld, any_req, gnt;
  // select 0 is the refill port, 1 the data port
  logic sel, prio_q, lock_q, lock_sel_q;

  assign dc_vld  = dc_rd_vld_i | dc_wr_vld_i;
  assign any_req = ic_vld_i | dc_vld;

  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (ic_vld_i && dc_vld) begin
      sel = prio_q;
    end else begin
      sel = dc_vld;
    end
  end

  // channel muxing, the id is set from the selected port
  assign bus_rd_req_o = sel ? dc_rd_vld_i : ic_vld_i;
  assign bus_wr_req_o = sel & dc_wr_vld_i;

  always_comb begin
    bus_rd_o    = sel ? dc_rd_i : ic_rd_i;
    bus_rd_o.id = sel ? BUS_ID_DCACHE : BUS_ID_ICACHE;
    bus_wr_o    = dc_wr_i;
    bus_wr_o.id = BUS_ID_DCACHE;
  end

  assign gnt      = (bus_rd_req_o & bus_rd_gnt_i) | (bus_wr_req_o & bus_wr_gnt_i);
  assign ic_pop_o = gnt & ~sel;
  assign dc_pop_o = gnt & sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else if (gnt) begin
      // move priority past the granted port
      prio_q <= ~sel;
      lock_q <= 1'b0;
    end else if (any_req) begin
      lock_q     <= 1'b1;
      lock_sel_q <= sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // after a grant the other waiting port goes next
  a_rr_to_dc : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_pop_o && dc_vld |=> sel);

  a_rr_to_ic : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dc_pop_o && ic_vld_i |=> !sel);

  // an ungranted read stays on the bus unchanged
  a_rd_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rd_req_o && !bus_rd_gnt_i |=> bus_rd_req_o && $stable(bus_rd_o));

endmodule

//--- hw/mem_adapter.sv
// memory adapter top level joining the refill and data ports to one split read/write bus
module mem_adapter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // instruction cache
  input  logic                          icache_req_i,
  input  mem_adapter_pkg::icache_req_t  icache_i,
  output logic                          icache_ack_o,
  output logic                          icache_rtrn_vld_o,
  output mem_adapter_pkg::icache_rtrn_t icache_rtrn_o,
  // data cache
  input  logic                          dcache_req_i,
  input  mem_adapter_pkg::dcache_req_t  dcache_i,
  output logic                          dcache_ack_o,
  output logic                          dcache_rtrn_vld_o,
  output mem_adapter_pkg::dcache_rtrn_t dcache_rtrn_o,
  // memory bus
  output logic                          bus_rd_req_o,
  output mem_adapter_pkg::bus_rd_req_t  bus_rd_o,
  input  logic                          bus_rd_gnt_i,
  output logic                          bus_wr_req_o,
  output mem_adapter_pkg::bus_wr_req_t  bus_wr_o,
  input  logic                          bus_wr_gnt_i,
  input  logic                          bus_rd_rsp_vld_i,
  input  mem_adapter_pkg::bus_rd_rsp_t  bus_rd_rsp_i,
  input  logic                          bus_wr_rsp_vld_i,
  input  logic                          bus_wr_rsp_id_i,
  output logic                          bus_wr_rsp_rdy_o
);
  import mem_adapter_pkg::*;

  logic        ic_vld, ic_pop, dc_rd_vld, dc_wr_vld, dc_pop;
  bus_rd_req_t ic_rd, dc_rd;
  bus_wr_req_t dc_wr;

  ifill_port i_ifill_port (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .icache_req_i      (icache_req_i),
    .icache_i          (icache_i),
    .icache_ack_o      (icache_ack_o),
    .req_vld_o         (ic_vld),
    .req_o             (ic_rd),
    .pop_i             (ic_pop),
    .rd_rsp_vld_i      (bus_rd_rsp_vld_i),
    .rd_rsp_i          (bus_rd_rsp_i),
    .icache_rtrn_vld_o (icache_rtrn_vld_o),
    .icache_rtrn_o     (icache_rtrn_o)
  );

  // only the data port writes, so responses are qualified by its id
  dcache_port i_dcache_port (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dcache_req_i      (dcache_req_i),
    .dcache_i          (dcache_i),
    .dcache_ack_o      (dcache_ack_o),
    .rd_vld_o          (dc_rd_vld),
    .rd_o              (dc_rd),
    .wr_vld_o          (dc_wr_vld),
    .wr_o              (dc_wr),
    .pop_i             (dc_pop),
    .rd_rsp_vld_i      (bus_rd_rsp_vld_i),
    .rd_rsp_i          (bus_rd_rsp_i),
    .wr_rsp_vld_i      (bus_wr_rsp_vld_i && (bus_wr_rsp_id_i == BUS_ID_DCACHE)),
    .wr_rsp_rdy_o      (bus_wr_rsp_rdy_o),
    .dcache_rtrn_vld_o (dcache_rtrn_vld_o),
    .dcache_rtrn_o     (dcache_rtrn_o)
  );

  bus_arbiter i_bus_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ic_vld_i     (ic_vld),
    .ic_rd_i      (ic_rd),
    .dc_rd_vld_i  (dc_rd_vld),
    .dc_rd_i      (dc_rd),
    .dc_wr_vld_i  (dc_wr_vld),
    .dc_wr_i      (dc_wr),
    .ic_pop_o     (ic_pop),
    .dc_pop_o     (dc_pop),
    .bus_rd_req_o (bus_rd_req_o),
    .bus_rd_o     (bus_rd_o),
    .bus_rd_gnt_i (bus_rd_gnt_i),
    .bus_wr_req_o (bus_wr_req_o),
    .bus_wr_o     (bus_wr_o),
    .bus_wr_gnt_i (bus_wr_gnt_i)
  );

endmodule

//--- dv/mem_bus_model.sv
// reactive memory bus model for the adapter testbench, grants with random delay and answers reads
module mem_bus_model (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         rd_req_i,
  input  mem_adapter_pkg::bus_rd_req_t rd_i,
  output logic                         rd_gnt_o,
  input  logic                         wr_req_i,
  input  mem_adapter_pkg::bus_wr_req_t wr_i,
  output logic                         wr_gnt_o,
  output logic                         rd_rsp_vld_o,
  output mem_adapter_pkg::bus_rd_rsp_t rd_rsp_o,
  output logic                         wr_rsp_vld_o,
  output logic                         wr_rsp_id_o,
  input  logic                         wr_rsp_rdy_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import mem_adapter_pkg::*;

  int          seed = 34986;
  bus_rd_req_t rd_pend [$];
  logic        wr_pend [$];
  int          rd_wait = 0;
  int          wr_wait = 0;
  int          rsp_wait = 0;
  int          beat = 0;
  logic        rd_gnt_q = 1'b0;
  logic        wr_gnt_q = 1'b0;
  logic        rd_rsp_vld_q = 1'b0;
  bus_rd_rsp_t rd_rsp_q = '0;
  logic        wr_rsp_vld_q = 1'b0;
  logic        wr_rsp_id_q = 1'b0;

  assign rd_gnt_o     = rd_gnt_q;
  assign wr_gnt_o     = wr_gnt_q;
  assign rd_rsp_vld_o = rd_rsp_vld_q;
  assign rd_rsp_o     = rd_rsp_q;
  assign wr_rsp_vld_o = wr_rsp_vld_q;
  assign wr_rsp_id_o  = wr_rsp_id_q;

  // 0 to 3 cycles
  function automatic int pick_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_gnt_q     <= 1'b0;
      wr_gnt_q     <= 1'b0;
      rd_rsp_vld_q <= 1'b0;
      wr_rsp_vld_q <= 1'b0;
      rd_pend.delete();
      wr_pend.delete();
      beat     = 0;
      rd_wait  = 0;
      wr_wait  = 0;
      rsp_wait = 0;
    end else begin
      // read channel, a request is taken when req and gnt meet at the edge
      if (rd_req_i && rd_gnt_q) begin
        rd_pend.push_back(rd_i);
        rd_gnt_q <= 1'b0;
        rd_wait = pick_delay();
      end else if (rd_req_i) begin
        if (rd_wait == 0) begin
          rd_gnt_q <= 1'b1;
        end else begin
          rd_wait--;
        end
      end
      // write channel
      if (wr_req_i && wr_gnt_q) begin
        wr_pend.push_back(wr_i.id);
        wr_gnt_q <= 1'b0;
        wr_wait = pick_delay();
      end else if (wr_req_i) begin
        if (wr_wait == 0) begin
          wr_gnt_q <= 1'b1;
        end else begin
          wr_wait--;
        end
      end

      ////////////////////////////////////////////////////////////
      // responses
      ////////////////////////////////////////////////////////////

      // beat k carries the word address plus k under a fixed tag
      rd_rsp_vld_q <= 1'b0;
      if (rd_pend.size() != 0) begin
        rd_rsp_vld_q  <= 1'b1;
        rd_rsp_q.data <= {16'hA5A5, 48'((rd_pend[0].addr >> 3) + beat)};
        rd_rsp_q.id   <= rd_pend[0].id;
        rd_rsp_q.last <= (beat == int'(rd_pend[0].blen));
        if (beat == int'(rd_pend[0].blen)) begin
          void'(rd_pend.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      // write response held until the adapter takes it
      if (wr_rsp_vld_q && wr_rsp_rdy_i) begin
        void'(wr_pend.pop_front());
        wr_rsp_vld_q <= 1'b0;
        rsp_wait = pick_delay();
      end else if (!wr_rsp_vld_q && wr_pend.size() != 0) begin
        if (rsp_wait == 0) begin
          wr_rsp_vld_q <= 1'b1;
          wr_rsp_id_q  <= wr_pend[0];
        end else begin
          rsp_wait--;
        end
      end
    end
  end

endmodule

//--- dv/tb_mem_adapter.sv
// testbench for the memory adapter, applies a table of refills, loads and stores and checks returns
module tb_mem_adapter;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_adapter_pkg::*;

  localparam int N_ROWS     = 14;
  localparam int MAX_CYCLES = 200 * N_ROWS + 100;
  localparam logic PORT_IC  = 1'b0;
  localparam logic PORT_DC  = 1'b1;

  typedef struct packed {
    logic               port;
    dcache_op_e         op;
    logic [PADDR_W-1:0] addr;
    logic [1:0]         size;
    logic               nc;
    logic [TID_W-1:0]   tid;
    logic [WORD_W-1:0]  data;
    logic [7:0]         exp_be;
    logic [WORD_W-1:0]  exp_data;
  } stim_t;

  // exp_data is word 0 of a refill or the load word, {A5A5, word address}
  stim_t tab [N_ROWS] = '{
    '{PORT_IC, DC_LOAD,  32'h00001048, 2'd3, 1'b0, 2'd1, 64'h0, 8'h00, 64'hA5A5000000000208},
    '{PORT_IC, DC_LOAD,  32'h00001058, 2'd3, 1'b1, 2'd2, 64'h0, 8'h00, 64'hA5A500000000020B},
    '{PORT_DC, DC_LOAD,  32'h00002010, 2'd3, 1'b0, 2'd0, 64'h0, 8'h00, 64'hA5A5000000000402},
    '{PORT_DC, DC_STORE, 32'h00003003, 2'd0, 1'b0, 2'd1, 64'h1122334455667788, 8'h08, 64'h0},
    '{PORT_DC, DC_STORE, 32'h00003006, 2'd1, 1'b0, 2'd2, 64'h99AABBCCDDEEFF00, 8'hC0, 64'h0},
    '{PORT_DC, DC_STORE, 32'h00003004, 2'd2, 1'b0, 2'd3, 64'h0F1E2D3C4B5A6978, 8'hF0, 64'h0},
    '{PORT_DC, DC_STORE, 32'h00003008, 2'd3, 1'b0, 2'd0, 64'hDEADBEEFCAFEF00D, 8'hFF, 64'h0},
    '{PORT_DC, DC_LOAD,  32'h00002024, 2'd2, 1'b0, 2'd1, 64'h0, 8'h00, 64'hA5A5000000000404},
    '{PORT_IC, DC_LOAD,  32'h00004000, 2'd3, 1'b0, 2'd3, 64'h0, 8'h00, 64'hA5A5000000000800},
    '{PORT_DC, DC_LOAD,  32'h00005FF8, 2'd3, 1'b0, 2'd2, 64'h0, 8'h00, 64'hA5A5000000000BFF},
    '{PORT_IC, DC_LOAD,  32'h0001003C, 2'd3, 1'b0, 2'd0, 64'h0, 8'h00, 64'hA5A5000000002004},
    '{PORT_DC, DC_STORE, 32'h00006001, 2'd0, 1'b0, 2'd3, 64'h0123456789ABCDEF, 8'h02, 64'h0},
    '{PORT_IC, DC_LOAD,  32'h00007FF8, 2'd3, 1'b1, 2'd1, 64'h0, 8'h00, 64'hA5A5000000000FFF},
    '{PORT_DC, DC_LOAD,  32'h00006000, 2'd0, 1'b0, 2'd3, 64'h0, 8'h00, 64'hA5A5000000000C00}
  };

  logic         clk;
  logic         rst_n;
  logic         icache_req;
  icache_req_t  icache;
  logic         icache_ack;
  logic         icache_rtrn_vld;
  icache_rtrn_t icache_rtrn;
  logic         dcache_req;
  dcache_req_t  dcache;
  logic         dcache_ack;
  logic         dcache_rtrn_vld;
  dcache_rtrn_t dcache_rtrn;
  logic         bus_rd_req;
  bus_rd_req_t  bus_rd;
  logic         bus_rd_gnt;
  logic         bus_wr_req;
  bus_wr_req_t  bus_wr;
  logic         bus_wr_gnt;
  logic         bus_rd_rsp_vld;
  bus_rd_rsp_t  bus_rd_rsp;
  logic         bus_wr_rsp_vld;
  logic         bus_wr_rsp_id;
  logic         bus_wr_rsp_rdy;

  // row indices still waiting for a return, per port and kind
  int   ic_q [$];
  int   ld_q [$];
  int   st_q [$];
  // row indices still waiting for their bus request
  int   ic_bus_q [$];
  int   ld_bus_q [$];
  int   wr_bus_q [$];
  int   cycles = 0;
  logic issued = 1'b0;

  mem_adapter UUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .icache_req_i      (icache_req),
    .icache_i          (icache),
    .icache_ack_o      (icache_ack),
    .icache_rtrn_vld_o (icache_rtrn_vld),
    .icache_rtrn_o     (icache_rtrn),
    .dcache_req_i      (dcache_req),
    .dcache_i          (dcache),
    .dcache_ack_o      (dcache_ack),
    .dcache_rtrn_vld_o (dcache_rtrn_vld),
    .dcache_rtrn_o     (dcache_rtrn),
    .bus_rd_req_o      (bus_rd_req),
    .bus_rd_o          (bus_rd),
    .bus_rd_gnt_i      (bus_rd_gnt),
    .bus_wr_req_o      (bus_wr_req),
    .bus_wr_o          (bus_wr),
    .bus_wr_gnt_i      (bus_wr_gnt),
    .bus_rd_rsp_vld_i  (bus_rd_rsp_vld),
    .bus_rd_rsp_i      (bus_rd_rsp),
    .bus_wr_rsp_vld_i  (bus_wr_rsp_vld),
    .bus_wr_rsp_id_i   (bus_wr_rsp_id),
    .bus_wr_rsp_rdy_o  (bus_wr_rsp_rdy)
  );

  mem_bus_model i_mem_bus_model (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .rd_req_i     (bus_rd_req),
    .rd_i         (bus_rd),
    .rd_gnt_o     (bus_rd_gnt),
    .wr_req_i     (bus_wr_req),
    .wr_i         (bus_wr),
    .wr_gnt_o     (bus_wr_gnt),
    .rd_rsp_vld_o (bus_rd_rsp_vld),
    .rd_rsp_o     (bus_rd_rsp),
    .wr_rsp_vld_o (bus_wr_rsp_vld),
    .wr_rsp_id_o  (bus_wr_rsp_id),
    .wr_rsp_rdy_i (bus_wr_rsp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("STATUS: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
      fail_run("value check failed");
    end
  endtask

  // drive one row on the rising edge and hold it until the port acks
  task automatic issue_row(input int idx);
    stim_t s;
    s = tab[idx];
    @(posedge clk);
    if (s.port == PORT_IC) begin
      icache_req <= 1'b1;
      icache     <= '{paddr: s.addr, nc: s.nc, tid: s.tid};
      dcache_req <= 1'b0;
    end else begin
      dcache_req <= 1'b1;
      dcache     <= '{op: s.op, paddr: s.addr, size: s.size, data: s.data, tid: s.tid};
      icache_req <= 1'b0;
    end
    issued = 1'b1;
    @(negedge clk);
    while ((s.port == PORT_IC) ? !icache_ack : !dcache_ack) begin
      @(negedge clk);
    end
    if (s.port == PORT_IC) begin
      ic_q.push_back(idx);
      ic_bus_q.push_back(idx);
    end else if (s.op == DC_LOAD) begin
      ld_q.push_back(idx);
      ld_bus_q.push_back(idx);
    end else begin
      st_q.push_back(idx);
      wr_bus_q.push_back(idx);
    end
  endtask

  task automatic check_line_return();
    stim_t s;
    int    k;
    if (ic_q.size() == 0) begin
      fail_run("refill return arrived with no refill outstanding");
    end else begin
      s = tab[ic_q.pop_front()];
      compare("refill tid", 64'(icache_rtrn.tid), 64'(s.tid));
      if (s.nc) begin
        compare("nc refill word 0", icache_rtrn.data[0], s.exp_data);
      end else begin
        for (k = 0; k < LINE_WORDS; k++) begin
          compare("refill line word", icache_rtrn.data[k], s.exp_data + 64'(k));
        end
      end
    end
  endtask

  task automatic check_data_return();
    stim_t s;
    if (dcache_rtrn.rtype == DC_LOAD_ACK && ld_q.size() != 0) begin
      s = tab[ld_q.pop_front()];
      compare("load tid", 64'(dcache_rtrn.tid), 64'(s.tid));
      compare("load data", dcache_rtrn.data, s.exp_data);
    end else if (dcache_rtrn.rtype == DC_STORE_ACK && st_q.size() != 0) begin
      s = tab[st_q.pop_front()];
      compare("store ack tid", 64'(dcache_rtrn.tid), 64'(s.tid));
    end else begin
      fail_run("data return arrived with no matching load or store outstanding");
    end
  endtask

  // a refill reads from the byte address of its first returned word
  task automatic check_bus_read();
    stim_t s;
    if (bus_rd.id == BUS_ID_ICACHE && ic_bus_q.size() != 0) begin
      s = tab[ic_bus_q.pop_front()];
      compare("refill bus read addr", 64'(bus_rd.addr), 64'({s.exp_data[28:0], 3'b000}));
      compare("refill bus read blen", 64'(bus_rd.blen),
              s.nc ? 64'd0 : 64'(LINE_WORDS - 1));
      compare("refill bus read size", 64'(bus_rd.size), 64'd3);
    end else if (bus_rd.id == BUS_ID_DCACHE && ld_bus_q.size() != 0) begin
      s = tab[ld_bus_q.pop_front()];
      compare("load bus read addr", 64'(bus_rd.addr), 64'(s.addr));
      compare("load bus read blen", 64'(bus_rd.blen), 64'd0);
      compare("load bus read size", 64'(bus_rd.size), 64'(s.size));
    end else begin
      fail_run("bus read granted with no matching refill or load outstanding");
    end
  endtask

  task automatic check_bus_write();
    stim_t s;
    if (wr_bus_q.size() == 0) begin
      fail_run("bus write granted with no store outstanding");
    end else begin
      s = tab[wr_bus_q.pop_front()];
      compare("bus write addr", 64'(bus_wr.addr), 64'(s.addr));
      compare("bus write data", bus_wr.data, s.data);
      compare("bus write byte enables", 64'(bus_wr.be), 64'(s.exp_be));
      compare("bus write size", 64'(bus_wr.size), 64'(s.size));
      compare("bus write id", 64'(bus_wr.id), 64'(BUS_ID_DCACHE));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////////////////////////

  // outputs are registered or settle long before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (!issued) begin
        compare("bus read request while idle", 64'(bus_rd_req), 64'd0);
        compare("bus write request while idle", 64'(bus_wr_req), 64'd0);
        compare("refill return while idle", 64'(icache_rtrn_vld), 64'd0);
        compare("data return while idle", 64'(dcache_rtrn_vld), 64'd0);
      end
      if (icache_rtrn_vld) begin
        check_line_return();
      end
      if (dcache_rtrn_vld) begin
        check_data_return();
      end
      if (bus_rd_req && bus_rd_gnt) begin
        check_bus_read();
      end
      if (bus_wr_req && bus_wr_gnt) begin
        check_bus_write();
      end
      // a data read beat holds off a write response in the same cycle
      if (bus_wr_rsp_vld) begin
        compare("write response ready", 64'(bus_wr_rsp_rdy),
                64'(!(bus_rd_rsp_vld && bus_rd_rsp.id == BUS_ID_DCACHE)));
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run($sformatf("timeout, returns still missing after %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    int i;
    icache_req = 1'b0;
    icache     = '0;
    dcache_req = 1'b0;
    dcache     = '0;
    rst_n      = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // idle cycles, nothing may move before the first request
    repeat (6) @(posedge clk);
    for (i = 0; i < N_ROWS; i++) begin
      issue_row(i);
    end
    @(posedge clk);
    icache_req <= 1'b0;
    dcache_req <= 1'b0;
    while (ic_q.size() + ld_q.size() + st_q.size() != 0) begin
      @(posedge clk);
    end
    // extra returns would show up here against empty queues
    repeat (10) @(posedge clk);
    if (ic_bus_q.size() == 0 && ld_bus_q.size() == 0 && wr_bus_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run("a request got its return without ever appearing on the bus");
    end
  end

endmodule

//--- src.f
hw/mem_adapter_pkg.sv
hw/sync_fifo.sv
hw/ifill_port.sv
hw/dcache_port.sv
hw/bus_arbiter.sv
hw/mem_adapter.sv
dv/mem_bus_model.sv
dv/tb_mem_adapter.sv

//--- run.sh
#!/usr/bin/env bash
# build the memory adapter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_mem_adapter -f src.f -o sim_mem_adapter

./obj_dir/sim_mem_adapter
